// File: hw/fetch_config.svh
// build-time options; RESET_PC must be even and match PC_WIDTH, DCT_DEPTH must stay at 2048
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ========================================
// program counter
// ========================================

// width of every fetch address
`define PC_WIDTH 32

// first fetch address after reset
`define RESET_PC 32'hFFFC0100

// ========================================
// predictor and decompression storage
// ========================================

// return stack entries, a power of two
`define RSB_DEPTH 8

// decompression table words, indexed by {cmpgrp, insn[15:8]} (11 bits)
`define DCT_DEPTH 2048

// table-compressed instructions enabled
`define SUPPORT_DCI 1'b1

`endif

// File: hw/isaPkg.sv
// ISA view of the front end only; opcode values cover just the classes that fetch redirects on
`include "fetch_config.svh"

package isaPkg;

	// one fetched or expanded instruction
	typedef logic [47:0] insnWord;

	// primary opcode lives in bits 5..0
	typedef enum logic [5:0] {
		NOP     = 6'h1C,
		JMP     = 6'h28,
		CALL    = 6'h29,
		RET     = 6'h2D,
		CMPRSSD = 6'h2F,
		BCC     = 6'h30
	} opcode;

	function automatic opcode opOf(insnWord w);
		return opcode'(w[5:0]);
	endfunction

	// ========================================
	// length code in bits 7..6
	// ========================================
	// 0 -> 4 bytes, 1 -> 6 bytes, 2/3 -> 2 bytes
	// table-compressed words are always one halfword
	function automatic logic [2:0] insLength(insnWord w);
		if (`SUPPORT_DCI && opOf(w) == CMPRSSD) begin
			return 3'd2;
		end
		case (w[7:6])
			2'd0: return 3'd4;
			2'd1: return 3'd6;
			default: return 3'd2;
		endcase
	endfunction

	// instruction classes seen by the redirect logic
	function automatic logic isBranch(insnWord w);
		return opOf(w) == BCC;
	endfunction

	function automatic logic isJump(insnWord w);
		return opOf(w) == JMP;
	endfunction

	function automatic logic isCall(insnWord w);
		return opOf(w) == CALL;
	endfunction

	function automatic logic isRet(insnWord w);
		return opOf(w) == RET;
	endfunction

endpackage

// File: hw/fetchPkg.sv
// fetch-side types; PC width comes from the config header and is shared by every block
`include "fetch_config.svh"

package fetchPkg;

	// ========================================
	// addresses and lengths
	// ========================================

	// byte address of an instruction
	typedef logic [`PC_WIDTH-1:0] pcT;

	// instruction length in bytes (2, 4 or 6)
	typedef logic [2:0] insLenT;

	// ========================================
	// fault reporting
	// ========================================

	// sticky fault code, cleared only by reset
	typedef enum logic [3:0] {
		PANIC_NONE             = 4'd0,
		PANIC_INVALID_IQ_STATE = 4'd1
	} panicT;

endpackage

// File: hw/insnExpander.sv
// fixed halfword expansion only; opcode is kept as-is, so compressed opcodes must be valid full ones
module insnExpander (
	input  logic [15:0]     cInsn_i,
	output isaPkg::insnWord expanded_o
);

	// fields of the compressed halfword
	logic [5:0]  cOp;
	logic [7:0]  cDisp;
	// sign-extended displacement for bits 31..16
	logic [15:0] wideDisp;

	assign cOp   = cInsn_i[5:0];
	assign cDisp = cInsn_i[15:8];

	// upper byte of the halfword becomes a 16-bit signed displacement
	assign wideDisp = {{8{cDisp[7]}}, cDisp};

	// ========================================
	// build the full word
	// ========================================
	always_comb begin
		// unused fields stay zero
		expanded_o = '0;

		// opcode is carried through unchanged
		expanded_o[5:0] = cOp;

		// length code 0 marks a full-size word
		expanded_o[7:6] = 2'b00;

		// register fields 15..8 remain zero
		expanded_o[15:8] = 8'h00;

		// displacement field
		expanded_o[31:16] = wideDisp;

		// upper fields 47..32 remain zero
		expanded_o[47:32] = 16'h0000;
	end

endmodule

// File: hw/decompressTable.sv
// combinational read, no write-through ordering guarantee for a lookup in the write cycle
`include "fetch_config.svh"

module decompressTable (
	input  logic            clk,
	input  logic            cs_i,
	input  logic            cyc_i,
	input  logic            stb_i,
	input  logic            we_i,
	input  logic [15:0]     adr_i,
	input  logic [47:0]     dat_i,
	output logic            ack_o,
	input  logic [10:0]     lookupIdx_i,
	output isaPkg::insnWord entry_o
);
	import isaPkg::*;

	// expanded instructions, one per 8-byte bus word
	insnWord tableMem [`DCT_DEPTH];

	logic       access;
	logic [10:0] wrIdx;

	// selected bus cycle
	assign access = cs_i & cyc_i & stb_i;

	// slave never waits
	assign ack_o = access;

	// word address from byte address
	assign wrIdx = adr_i[13:3];

	always_ff @(posedge clk) begin
		if (access && we_i) begin
			tableMem[wrIdx] <= dat_i;
		end
	end

	// lookup by {group, index byte}
	assign entry_o = tableMem[lookupIdx_i];

	// a write strobe must only reach this table when it is selected
	assert property (@(posedge clk) (cyc_i && stb_i && we_i) |-> cs_i)
		else $error("decompressTable: write strobe without chip select");

endmodule

// File: hw/returnStack.sv
// no recovery of stomped returns; a misprediction leaves the stack as it was speculatively updated
`include "fetch_config.svh"

module returnStack (
	input  logic           clk,
	input  logic           rst,
	input  logic           push_i,
	input  fetchPkg::pcT   pushPc_i,
	input  logic           pop_i,
	output fetchPkg::pcT   retPc_o
);
	import fetchPkg::*;

	localparam int PtrW = $clog2(`RSB_DEPTH);

	// circular storage, oldest entries are overwritten on overflow
	pcT stack [`RSB_DEPTH];

	// sp points at the current top
	logic [PtrW-1:0] sp;
	logic [PtrW-1:0] spUp;
	logic [PtrW-1:0] spDown;

	assign spUp   = sp + 1'b1;
	assign spDown = sp - 1'b1;

	// ========================================
	// push / pop
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			sp <= '0;
			// empty stack predicts the reset vector
			for (int i = 0; i < `RSB_DEPTH; i++) begin
				stack[i] <= `RESET_PC;
			end
		end else if (push_i) begin
			// new top one above the old
			stack[spUp] <= pushPc_i;
			sp <= spUp;
		end else if (pop_i) begin
			// underflow just wraps around
			sp <= spDown;
		end
	end

	// prediction for a RET currently at the head
	assign retPc_o = stack[sp];

	// the head is one instruction, so it cannot be a CALL and a RET at once
	assert property (@(posedge clk) disable iff (rst) !(push_i && pop_i))
		else $error("returnStack: push and pop in the same cycle");

endmodule

// File: hw/fetchBuffer.sv
// single issue, two slots; a taken head holds fetch until it is queued, odd missPc is not allowed
`include "fetch_config.svh"

module fetchBuffer (
	input  logic             clk,
	input  logic             rst,
	input  logic             freezePc_i,
	input  isaPkg::insnWord  insn_i,
	input  logic             phit_i,
	input  isaPkg::insnWord  expanded_i,
	input  isaPkg::insnWord  tableEntry_i,
	input  logic             branchMiss_i,
	input  fetchPkg::pcT     missPc_i,
	input  logic             predictTaken_i,
	input  logic             queued_i,
	input  logic [1:0]       nopFetch_i,
	input  fetchPkg::pcT     retPc_i,
	output fetchPkg::pcT     pc_o,
	output logic             fetchValid_o,
	output isaPkg::insnWord  fetchInstr_o,
	output fetchPkg::pcT     fetchPc_o,
	output fetchPkg::insLenT fetchLen_o,
	output logic             takeBranch_o,
	output logic             rsbPush_o,
	output fetchPkg::pcT     rsbPushPc_o,
	output logic             rsbPop_o,
	output fetchPkg::panicT  panic_o
);
	import isaPkg::*;
	import fetchPkg::*;

	// slot 0 is A, slot 1 is B
	logic [1:0] slotV;
	insnWord    slotInstr [2];
	pcT         slotPc [2];
	insLenT     slotLen [2];
	// head pointer
	logic       head;

	insnWord selInsn;
	insLenT  rawLen;
	logic    headV;
	insnWord headInstr;
	pcT      headPc;
	insLenT  headLen;
	pcT      dispX2;
	pcT      headTarget;
	logic    redirect;
	logic    fillEn;
	logic    fillSlot;

	// ========================================
	// incoming word
	// ========================================
	// table first, then the fixed expander, else raw
	always_comb begin
		if (`SUPPORT_DCI && opOf(insn_i) == CMPRSSD) begin
			selInsn = tableEntry_i;
		end else if (insn_i[7]) begin
			selInsn = expanded_i;
		end else begin
			selInsn = insn_i;
		end
	end

	// length of what was fetched, not of the expansion
	assign rawLen = insLength(insn_i);

	// ========================================
	// head view and target
	// ========================================
	assign headV     = slotV[head];
	assign headInstr = slotInstr[head];
	assign headPc    = slotPc[head];
	assign headLen   = slotLen[head];

	// halfword-scaled branch displacement
	assign dispX2 = {{(`PC_WIDTH-17){headInstr[31]}}, headInstr[31:16], 1'b0};

	always_comb begin
		case (opOf(headInstr))
			RET: headTarget = retPc_i;
			// absolute halfword target
			JMP, CALL: headTarget = pcT'({headInstr[39:8], 1'b0});
			// Bcc is relative to the next instruction
			default: headTarget = headPc + pcT'(headLen) + dispX2;
		endcase
	end

	// conditional branches follow the predictor, the rest always redirect
	assign redirect = headV && ((isBranch(headInstr) && predictTaken_i) ||
		isJump(headInstr) || isCall(headInstr) || isRet(headInstr));
	assign takeBranch_o = redirect;

	// fill A before B, only on a cache hit and with no redirect pending
	assign fillEn   = phit_i && !branchMiss_i && !redirect && (slotV != 2'b11);
	assign fillSlot = slotV[0];

	// ========================================
	// control state
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_o    <= `RESET_PC;
			slotV   <= 2'b00;
			head    <= 1'b0;
			panic_o <= PANIC_NONE;
		end else if (branchMiss_i) begin
			// flush wins over everything
			pc_o  <= missPc_i;
			slotV <= 2'b00;
			head  <= 1'b0;
		end else begin
			if (redirect) begin
				// younger slot is on the wrong path
				pc_o <= headTarget;
				slotV[~head] <= 1'b0;
			end else if (fillEn) begin
				slotV[fillSlot] <= 1'b1;
				if (!freezePc_i) begin
					pc_o <= pc_o + pcT'(rawLen);
				end
			end
			// head consumed by the issue queue
			if (queued_i) begin
				if (headV) begin
					slotV[head] <= 1'b0;
					head <= ~head;
				end else begin
					panic_o <= PANIC_INVALID_IQ_STATE;
				end
			end else if (slotV == 2'b00) begin
				head <= 1'b0;
			end
			// per-slot nop invalidation
			if (nopFetch_i[0]) begin
				slotV[0] <= 1'b0;
			end
			if (nopFetch_i[1]) begin
				slotV[1] <= 1'b0;
			end
		end
	end

	// payload, written only on a fill
	always_ff @(posedge clk) begin
		if (fillEn) begin
			slotInstr[fillSlot] <= selInsn;
			slotPc[fillSlot]    <= pc_o;
			slotLen[fillSlot]   <= rawLen;
		end
	end

	// issue queue side
	assign fetchValid_o = headV;
	assign fetchInstr_o = headInstr;
	assign fetchPc_o    = headPc;
	assign fetchLen_o   = headLen;

	// return stack updates on consumed CALL / RET
	assign rsbPush_o   = queued_i && headV && isCall(headInstr);
	assign rsbPushPc_o = headPc + pcT'(headLen);
	assign rsbPop_o    = queued_i && headV && isRet(headInstr);

	// outside a panic, an empty head under a queue pulse means the whole buffer is empty
	assert property (@(posedge clk) disable iff (rst)
		(queued_i && !headV && panic_o == PANIC_NONE) |-> (slotV == 2'b00))
		else $error("fetchBuffer: head points at an empty slot while the other is full");

	assert property (@(posedge clk) disable iff (rst) !pc_o[0])
		else $error("fetchBuffer: odd fetch address");

endmodule

// File: hw/fetchUnit.sv
// top of the fetch front end; instruction cache is external and must answer in the cycle pc_o is shown
module fetchUnit (
	input  logic             clk,
	input  logic             rst,
	// decompression table bus
	input  logic             cs_i,
	input  logic             cyc_i,
	input  logic             stb_i,
	input  logic             we_i,
	input  logic [15:0]      adr_i,
	input  logic [47:0]      dat_i,
	output logic             ack_o,
	input  logic [2:0]       cmpgrp_i,
	// cache and control
	input  logic             freezePc_i,
	input  isaPkg::insnWord  insn_i,
	input  logic             phit_i,
	input  logic             branchMiss_i,
	input  fetchPkg::pcT     missPc_i,
	input  logic             predictTaken_i,
	input  logic             queued_i,
	input  logic [1:0]       nopFetch_i,
	// issue queue side
	output fetchPkg::pcT     pc_o,
	output logic             fetchValid_o,
	output isaPkg::insnWord  fetchInstr_o,
	output fetchPkg::pcT     fetchPc_o,
	output fetchPkg::insLenT fetchLen_o,
	output logic             takeBranch_o,
	output fetchPkg::panicT  panic_o
);
	import isaPkg::*;
	import fetchPkg::*;

	insnWord     expanded;
	insnWord     tableEntry;
	logic [10:0] lookupIdx;
	pcT          retPc;
	pcT          rsbPushPc;
	logic        rsbPush;
	logic        rsbPop;

	// group selects one 256-entry bank
	assign lookupIdx = {cmpgrp_i, insn_i[15:8]};

	insnExpander uExpander (
		.cInsn_i   (insn_i[15:0]),
		.expanded_o(expanded)
	);

	decompressTable uTable (
		.clk        (clk),
		.cs_i       (cs_i),
		.cyc_i      (cyc_i),
		.stb_i      (stb_i),
		.we_i       (we_i),
		.adr_i      (adr_i),
		.dat_i      (dat_i),
		.ack_o      (ack_o),
		.lookupIdx_i(lookupIdx),
		.entry_o    (tableEntry)
	);

	returnStack uRsb (
		.clk     (clk),
		.rst     (rst),
		.push_i  (rsbPush),
		.pushPc_i(rsbPushPc),
		.pop_i   (rsbPop),
		.retPc_o (retPc)
	);

	fetchBuffer uFetchBuf (
		.clk           (clk),
		.rst           (rst),
		.freezePc_i    (freezePc_i),
		.insn_i        (insn_i),
		.phit_i        (phit_i),
		.expanded_i    (expanded),
		.tableEntry_i  (tableEntry),
		.branchMiss_i  (branchMiss_i),
		.missPc_i      (missPc_i),
		.predictTaken_i(predictTaken_i),
		.queued_i      (queued_i),
		.nopFetch_i    (nopFetch_i),
		.retPc_i       (retPc),
		.pc_o          (pc_o),
		.fetchValid_o  (fetchValid_o),
		.fetchInstr_o  (fetchInstr_o),
		.fetchPc_o     (fetchPc_o),
		.fetchLen_o    (fetchLen_o),
		.takeBranch_o  (takeBranch_o),
		.rsbPush_o     (rsbPush),
		.rsbPushPc_o   (rsbPushPc),
		.rsbPop_o      (rsbPop),
		.panic_o       (panic_o)
	);

endmodule

// File: tb/clockGen.sv
// free-running clock of period 8; reset is high for 4 rising edges and drops on a falling edge
module clockGen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: tb/fetchTb.sv
// directed tests; the cache model only decodes pc bits 10..1, so every test program stays in 2 KB
`include "fetch_config.svh"

module fetchTb;
	import isaPkg::*;
	import fetchPkg::*;

	localparam int NumTests = 6;
	localparam int CyclesPerTest = 200;
	localparam pcT Base = `RESET_PC;

	logic        clk;
	logic        rst;
	logic        busCs, busCyc, busStb, busWe, busAck;
	logic [15:0] busAdr;
	insnWord     busDat;
	logic [2:0]  cmpgrp;
	logic        freezePc, phit, branchMiss, predictTaken, queued;
	insnWord     insn;
	pcT          missPc;
	logic [1:0]  nopFetch;
	pcT          pc;
	logic        fetchValid;
	insnWord     fetchInstr;
	pcT          fetchPc;
	insLenT      fetchLen;
	logic        takeBranch;
	panicT       panic;

	// program memory, one word per halfword address
	insnWord progMem [1024];
	// what the bus wrote into the decompression table
	insnWord tableShadow [`DCT_DEPTH];
	insnWord seqQ [$];
	logic    hitOn;
	int      seed;

	clockGen uClk (
		.clk(clk),
		.rst(rst)
	);

	fetchUnit dut (
		.clk           (clk),
		.rst           (rst),
		.cs_i          (busCs),
		.cyc_i         (busCyc),
		.stb_i         (busStb),
		.we_i          (busWe),
		.adr_i         (busAdr),
		.dat_i         (busDat),
		.ack_o         (busAck),
		.cmpgrp_i      (cmpgrp),
		.freezePc_i    (freezePc),
		.insn_i        (insn),
		.phit_i        (phit),
		.branchMiss_i  (branchMiss),
		.missPc_i      (missPc),
		.predictTaken_i(predictTaken),
		.queued_i      (queued),
		.nopFetch_i    (nopFetch),
		.pc_o          (pc),
		.fetchValid_o  (fetchValid),
		.fetchInstr_o  (fetchInstr),
		.fetchPc_o     (fetchPc),
		.fetchLen_o    (fetchLen),
		.takeBranch_o  (takeBranch),
		.panic_o       (panic)
	);

	// ========================================
	// reference rules
	// ========================================

	// untouched memory reads as 4-byte NOPs tagged with their own address
	function automatic insnWord fillWord(logic [9:0] idx);
		return {22'h2A5, idx, 8'h00, 2'b00, NOP};
	endfunction

	// program memory slot of a byte address
	function automatic logic [9:0] memIdx(pcT a);
		return a[10:1];
	endfunction

	// code 0 -> 4, code 1 -> 6, else 2; CMPRSSD is always 2
	function automatic int byteLen(insnWord w);
		if (w[5:0] == CMPRSSD) begin
			return 2;
		end
		case (w[7:6])
			2'd0: return 4;
			2'd1: return 6;
			default: return 2;
		endcase
	endfunction

	// halfword expansion: opcode kept, upper byte sign-extended into 31..16
	function automatic insnWord expandRule(logic [15:0] h);
		insnWord w;
		w = '0;
		w[5:0] = h[5:0];
		w[31:16] = {{8{h[15]}}, h[15:8]};
		return w;
	endfunction

	// what the head should show for a raw fetched word
	function automatic insnWord expectFetched(insnWord w);
		if (w[5:0] == CMPRSSD) begin
			return tableShadow[{cmpgrp, w[15:8]}];
		end
		if (w[7]) begin
			return expandRule(w[15:0]);
		end
		return w;
	endfunction

	function automatic insnWord mkWord(opcode op, logic [1:0] lenCode, logic [7:0] mid,
		logic [15:0] field);
		return {16'h0000, field, mid, lenCode, op};
	endfunction

	// absolute halfword target in bits 39..8, 6 bytes long
	function automatic insnWord mkAbs(opcode op, pcT tgt);
		return {8'h00, 1'b0, tgt[31:1], 2'b01, op};
	endfunction

	function automatic insnWord randWord();
		insnWord w;
		w = insnWord'({$random(seed), $random(seed)});
		// keep table entries from redirecting
		w[5:0] = NOP;
		return w;
	endfunction

	// ========================================
	// checks and failure
	// ========================================

	task automatic stopRun(string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic checkInsn(insnWord got, insnWord exp, string what);
		if (got !== exp) begin
			stopRun($sformatf("error at %0t: %s insn %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic checkPc(pcT got, pcT exp, string what);
		if (got !== exp) begin
			stopRun($sformatf("error at %0t: %s pc %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic checkLen(insLenT got, insLenT exp, string what);
		if (got !== exp) begin
			stopRun($sformatf("error at %0t: %s length %0d, expected %0d", $time, what,
				got, exp));
		end
	endtask

	task automatic checkPanic(panicT got, panicT exp, string what);
		if (got !== exp) begin
			stopRun($sformatf("error at %0t: %s panic %s, expected %s", $time, what,
				got.name(), exp.name()));
		end
	endtask

	task automatic checkFlag(logic got, logic exp, string what);
		if (got !== exp) begin
			stopRun($sformatf("error at %0t: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	// ========================================
	// drivers
	// ========================================

	// falling edge: cache answers for the pc now shown
	task automatic nextCycle();
		@(negedge clk);
		insn = progMem[pc[10:1]];
		phit = hitOn;
	endtask

	task automatic waitHead();
		int n;
		n = 0;
		while (fetchValid !== 1'b1) begin
			if (n == 20) begin
				stopRun($sformatf("no valid head showed up within 20 cycles, time %0t", $time));
			end
			nextCycle();
			n++;
		end
	endtask

	// one-cycle queue pulse
	task automatic consumeHead();
		queued = 1'b1;
		nextCycle();
		queued = 1'b0;
	endtask

	task automatic takeHead(pcT a, string what);
		waitHead();
		checkPc(fetchPc, a, what);
		checkInsn(fetchInstr, expectFetched(progMem[a[10:1]]), what);
		checkLen(fetchLen, insLenT'(byteLen(progMem[a[10:1]])), what);
		consumeHead();
	endtask

	// restart fetch through a branch miss
	task automatic flushTo(pcT a);
		nextCycle();
		branchMiss = 1'b1;
		missPc = a;
		nextCycle();
		branchMiss = 1'b0;
		checkPc(pc, a, "flush target");
		checkFlag(fetchValid, 1'b0, "head valid after flush");
	endtask

	task automatic placeSeq(pcT start);
		pcT a;
		a = start;
		foreach (seqQ[i]) begin
			progMem[a[10:1]] = seqQ[i];
			a = a + pcT'(byteLen(seqQ[i]));
		end
	endtask

	task automatic checkSeq(pcT start);
		pcT a;
		a = start;
		foreach (seqQ[i]) begin
			takeHead(a, "sequential head");
			a = a + pcT'(byteLen(seqQ[i]));
		end
	endtask

	task automatic busWrite(logic [10:0] idx, insnWord d);
		nextCycle();
		busCs = 1'b1;
		busCyc = 1'b1;
		busStb = 1'b1;
		busWe = 1'b1;
		busAdr = {2'b00, idx, 3'b000};
		busDat = d;
		@(posedge clk);
		checkFlag(busAck, 1'b1, "ack during strobe");
		tableShadow[idx] = d;
		nextCycle();
		busCs = 1'b0;
		busCyc = 1'b0;
		busStb = 1'b0;
		busWe = 1'b0;
		@(posedge clk);
		checkFlag(busAck, 1'b0, "ack after strobe");
	endtask

	// ========================================
	// tests
	// ========================================

	task automatic testReset();
		checkPc(pc, Base, "reset");
		checkFlag(fetchValid, 1'b0, "head valid after reset");
		checkPanic(panic, PANIC_NONE, "reset");
	endtask

	task automatic testSequential();
		seqQ = {mkWord(NOP, 2'd0, 8'h11, 16'h1001), mkWord(NOP, 2'd1, 8'h22, 16'h2002),
			mkWord(NOP, 2'd2, 8'h7E, 16'h0000), mkWord(NOP, 2'd3, 8'h90, 16'h0000),
			mkWord(NOP, 2'd0, 8'h33, 16'h3003)};
		placeSeq(Base);
		hitOn = 1'b1;
		checkSeq(Base);
		// slots still fill while the pc holds
		freezePc = 1'b1;
		flushTo(Base + 32'h40);
		repeat (3) nextCycle();
		checkFlag(fetchValid, 1'b1, "fill under freeze");
		checkPc(pc, Base + 32'h40, "frozen");
		freezePc = 1'b0;
	endtask

	task automatic testCompressed();
		cmpgrp = 3'd5;
		for (int i = 0; i < 4; i++) begin
			busWrite({3'd5, 8'hA0 + 8'(i)}, randWord());
		end
		seqQ = {mkWord(CMPRSSD, 2'd0, 8'hA0, 16'h0000), mkWord(CMPRSSD, 2'd0, 8'hA3, 16'h0000),
			mkWord(NOP, 2'd2, 8'h85, 16'h0000), mkWord(NOP, 2'd0, 8'h44, 16'h4004)};
		placeSeq(Base + 32'h80);
		flushTo(Base + 32'h80);
		checkSeq(Base + 32'h80);
	endtask

	task automatic testRedirects();
		insnWord bcc;
		logic [15:0] disp;
		pcT tgt;
		// backward branch exercises the sign extension
		disp = 16'hFFF0;
		bcc = mkWord(BCC, 2'd0, 8'h00, disp);
		tgt = Base + 32'h100 + pcT'(byteLen(bcc)) + {{15{disp[15]}}, disp, 1'b0};
		progMem[memIdx(Base + 32'h100)] = bcc;
		predictTaken = 1'b1;
		flushTo(Base + 32'h100);
		waitHead();
		checkFlag(takeBranch, 1'b1, "taken branch");
		takeHead(Base + 32'h100, "branch head");
		takeHead(tgt, "branch target");
		predictTaken = 1'b0;
		flushTo(Base + 32'h100);
		waitHead();
		checkFlag(takeBranch, 1'b0, "not-taken branch");
		takeHead(Base + 32'h100, "branch head");
		takeHead(Base + 32'h104, "fall through");
		progMem[memIdx(Base + 32'h180)] = mkAbs(JMP, Base + 32'h400);
		flushTo(Base + 32'h180);
		waitHead();
		checkFlag(takeBranch, 1'b1, "jump");
		takeHead(Base + 32'h180, "jump head");
		takeHead(Base + 32'h400, "jump target");
	endtask

	task automatic testCallReturn();
		pcT s;
		pcT t1;
		pcT t2;
		s = Base + 32'h200;
		t1 = Base + 32'h300;
		t2 = Base + 32'h380;
		progMem[s[10:1]] = mkAbs(CALL, t1);
		progMem[t1[10:1]] = mkAbs(CALL, t2);
		progMem[t2[10:1]] = mkWord(RET, 2'd0, 8'h00, 16'h0000);
		progMem[memIdx(t1 + 32'd6)] = mkWord(RET, 2'd0, 8'h00, 16'h0000);
		flushTo(s);
		takeHead(s, "outer call");
		takeHead(t1, "inner call");
		takeHead(t2, "inner return");
		// returns unwind in reverse order
		takeHead(t1 + pcT'(byteLen(progMem[t1[10:1]])), "outer return");
		takeHead(s + pcT'(byteLen(progMem[s[10:1]])), "after outer call");
	endtask

	task automatic testFlushFaults();
		flushTo(Base + 32'h500);
		repeat (2) nextCycle();
		flushTo(Base + 32'h600);
		takeHead(Base + 32'h600, "first head after miss");
		// A and B filled, then B dropped
		flushTo(Base + 32'h680);
		repeat (2) nextCycle();
		nopFetch = 2'b10;
		nextCycle();
		nopFetch = 2'b00;
		takeHead(Base + 32'h680, "slot A kept");
		takeHead(Base + 32'h688, "after dropped slot B");
		// no fills, so the head stays empty
		hitOn = 1'b0;
		flushTo(Base + 32'h6C0);
		checkPanic(panic, PANIC_NONE, "before empty queue");
		consumeHead();
		checkPanic(panic, PANIC_INVALID_IQ_STATE, "empty head queued");
		repeat (2) nextCycle();
		checkPanic(panic, PANIC_INVALID_IQ_STATE, "sticky panic");
	endtask

	// ========================================
	// run control
	// ========================================

	initial begin
		repeat (NumTests * CyclesPerTest) @(posedge clk);
		stopRun($sformatf("timeout: tests still running after %0d cycles",
			NumTests * CyclesPerTest));
	end

	initial begin
		seed = 32'h775d;
		hitOn = 1'b0;
		busCs = 1'b0;
		busCyc = 1'b0;
		busStb = 1'b0;
		busWe = 1'b0;
		busAdr = '0;
		busDat = '0;
		cmpgrp = '0;
		freezePc = 1'b0;
		insn = '0;
		phit = 1'b0;
		branchMiss = 1'b0;
		missPc = '0;
		predictTaken = 1'b0;
		queued = 1'b0;
		nopFetch = 2'b00;
		for (int i = 0; i < 1024; i++) begin
			progMem[i] = fillWord(10'(i));
		end
		@(negedge rst);
		nextCycle();
		testReset();
		testSequential();
		testCompressed();
		testRedirects();
		testCallReturn();
		testFlushFaults();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: project.f
+incdir+hw
hw/isaPkg.sv
hw/fetchPkg.sv
hw/insnExpander.sv
hw/decompressTable.sv
hw/returnStack.sv
hw/fetchBuffer.sv
hw/fetchUnit.sv
tb/clockGen.sv
tb/fetchTb.sv

// File: Makefile
# Verilator flow for the fetch front end testbench

TOP := fetchTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

# build, run, then look for the pass line in the log
sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o simv
	./obj_dir/simv 2>&1 | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
